// ==== vlog.f ====
+incdir+logic
logic/rv_exec_pkg.sv
logic/rv_regfile.sv
logic/rv_decode.sv
logic/rv_execute.sv
logic/rv_result.sv
logic/rv_exec_top.sv
sim/rv_exec_assertions.sv
sim/rv_exec_tb.sv

// ==== sim/rv_exec_tb.sv ====
`timescale 1ns/1ps
`include "rv_exec_cfg.svh"

module rv_exec_tb;
    import rv_exec_pkg::*;

    logic    clk;
    logic    rst_n;
    logic    inst_req;
    inst_t   inst;
    logic    inst_ack;
    retire_t retire;

    // reference model state
    xlen_t   ref_regs [`RV_NREGS];
    xlen_t   ref_pc;
    retire_t expected_q [$];
    retire_t last_retire;
    retire_t exp_rec;
    inst_t   prog [$];
    logic    ack_q = 1'b0;
    int      cycles = 0;
    int      cycle_limit = 0;
    int      k;
    // beq bne blt bge bltu bgeu
    logic [2:0] br_f3 [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    // load, store, system, all zero, all ones
    logic [6:0] bad_opc [5] = '{7'b0000011, 7'b0100011, 7'b1110011, 7'b0000000, 7'b1111111};

    rv_exec_top dut_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .inst_req (inst_req),
        .inst     (inst),
        .inst_ack (inst_ack),
        .retire   (retire)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_retire(input retire_t exp, input retire_t got);
        retire_t e;
        retire_t g;
        e = exp;
        g = got;
        // value is only meaningful when rd is written
        if (!exp.wen) begin
            e.value = '0;
            g.value = '0;
        end
        if (g !== e) begin
            report_failure($sformatf("Mismatch retire: expected %h, got %h", e, g));
        end
    endtask

    task automatic check_value(input xlen_t exp, input xlen_t got);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch retire.value: expected %h, got %h", exp, got));
        end
    endtask

    // instruction encoders
    function automatic inst_t encode_r(input logic [6:0] f7, input reg_idx_t rs2,
                                       input reg_idx_t rs1, input logic [2:0] f3,
                                       input reg_idx_t rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic inst_t encode_i(input logic [11:0] imm, input reg_idx_t rs1,
                                       input logic [2:0] f3, input reg_idx_t rd,
                                       input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic inst_t encode_b(input logic [12:0] off, input reg_idx_t rs2,
                                       input reg_idx_t rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic inst_t encode_j(input logic [20:0] off, input reg_idx_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // expected retire record that also advances model regs and pc
    function automatic retire_t ref_retire(input inst_t i);
        retire_t    r;
        logic [2:0] f3;
        logic [6:0] f7;
        xlen_t      a;
        xlen_t      b;
        xlen_t      imm_i;
        logic       wr;
        logic       taken;
        f3        = i[14:12];
        f7        = i[31:25];
        a         = ref_regs[i[19:15]];
        b         = ref_regs[i[24:20]];
        imm_i     = xlen_t'($signed(i[31:20]));
        wr        = 1'b0;
        taken     = 1'b0;
        r.pc      = ref_pc;
        r.next_pc = ref_pc + 64'd4;
        r.rd      = i[11:7];
        r.value   = '0;
        case (i[6:0])
            7'b0110111: begin
                r.value = xlen_t'($signed({i[31:12], 12'b0}));
                wr      = 1'b1;
            end
            7'b0010111: begin
                r.value = ref_pc + xlen_t'($signed({i[31:12], 12'b0}));
                wr      = 1'b1;
            end
            7'b1101111: begin
                r.value   = ref_pc + 64'd4;
                r.next_pc = ref_pc + xlen_t'($signed({i[31], i[19:12], i[20], i[30:21], 1'b0}));
                wr        = 1'b1;
            end
            7'b1100111: begin
                // target bit 0 always cleared
                if (f3 == 3'b000) begin
                    r.value   = ref_pc + 64'd4;
                    r.next_pc = (a + imm_i) & ~xlen_t'(1);
                    wr        = 1'b1;
                end
            end
            7'b1100011: begin
                case (f3)
                    3'b000:  taken = (a == b);
                    3'b001:  taken = (a != b);
                    3'b100:  taken = ($signed(a) < $signed(b));
                    3'b101:  taken = ($signed(a) >= $signed(b));
                    3'b110:  taken = (a < b);
                    3'b111:  taken = (a >= b);
                    default: taken = 1'b0;
                endcase
                if (taken) begin
                    r.next_pc = ref_pc + xlen_t'($signed({i[31], i[7], i[30:25], i[11:8], 1'b0}));
                end
            end
            7'b0010011: begin
                case (f3)
                    3'b000:  r.value = a + imm_i;
                    3'b001:  r.value = a << i[25:20];
                    3'b010:  r.value = xlen_t'($signed(a) < $signed(imm_i));
                    3'b011:  r.value = xlen_t'(a < imm_i);
                    3'b100:  r.value = a ^ imm_i;
                    3'b101:  r.value = i[30] ? xlen_t'($signed(a) >>> i[25:20]) : a >> i[25:20];
                    3'b110:  r.value = a | imm_i;
                    default: r.value = a & imm_i;
                endcase
                // 6 bit shamt with only the sra flag above it
                wr = (f3 == 3'b001) ? (i[31:26] == 6'b0) :
                     (f3 == 3'b101) ? (i[31:26] == 6'b0 || i[31:26] == 6'b010000) : 1'b1;
            end
            7'b0110011: begin
                case (f3)
                    3'b000:  r.value = f7[5] ? a - b : a + b;
                    3'b001:  r.value = a << b[5:0];
                    3'b010:  r.value = xlen_t'($signed(a) < $signed(b));
                    3'b011:  r.value = xlen_t'(a < b);
                    3'b100:  r.value = a ^ b;
                    3'b101:  r.value = f7[5] ? xlen_t'($signed(a) >>> b[5:0]) : a >> b[5:0];
                    3'b110:  r.value = a | b;
                    default: r.value = a & b;
                endcase
                wr = (f7 == 7'b0) || (f7 == 7'b0100000 && (f3 == 3'b000 || f3 == 3'b101));
            end
            7'b0011011: begin
                r.value = xlen_t'($signed(a[31:0] + imm_i[31:0]));
                wr      = (f3 == 3'b000);
            end
            7'b0111011: begin
                r.value = f7[5] ? xlen_t'($signed(a[31:0] - b[31:0])) :
                                  xlen_t'($signed(a[31:0] + b[31:0]));
                wr      = (f3 == 3'b000) && (f7 == 7'b0 || f7 == 7'b0100000);
            end
            default: wr = 1'b0;
        endcase
        r.wen = wr && (i[11:7] != 5'd0);
        if (r.wen) begin
            ref_regs[i[11:7]] = r.value;
        end
        ref_pc = r.next_pc;
        return r;
    endfunction

    // random op, op-imm, lui, auipc or w form
    function automatic inst_t random_alu();
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic        alt;
        rd  = reg_idx_t'($urandom_range(0, 31));
        rs1 = reg_idx_t'($urandom_range(0, 31));
        rs2 = reg_idx_t'($urandom_range(0, 31));
        f3  = 3'($urandom_range(0, 7));
        imm = 12'($urandom());
        alt = 1'($urandom());
        case ($urandom_range(0, 5))
            0: return encode_r((alt && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'b0,
                               rs2, rs1, f3, rd, 7'b0110011);
            1: begin
                if (f3 == 3'b001) begin
                    imm = {6'b0, imm[5:0]};
                end else if (f3 == 3'b101) begin
                    imm = {1'b0, alt, 4'b0, imm[5:0]};
                end
                return encode_i(imm, rs1, f3, rd, 7'b0010011);
            end
            2: return {20'($urandom()), rd, 7'b0110111};
            3: return {20'($urandom()), rd, 7'b0010111};
            4: return encode_i(imm, rs1, 3'b000, rd, 7'b0011011);
            default: return encode_r(alt ? 7'b0100000 : 7'b0, rs2, rs1, 3'b000, rd, 7'b0111011);
        endcase
    endfunction

    // sample ack just after an edge and never on it
    task automatic wait_ack(input logic level);
        while (inst_ack !== level) begin
            @(posedge clk);
            #10;
        end
    endtask

    // one four phase transfer with req held a random while after ack
    task automatic run_instruction(input inst_t word);
        int hold;
        hold = $urandom_range(0, 8);
        expected_q.push_back(ref_retire(word));
        inst     = word;
        inst_req = 1'b1;
        wait_ack(1'b1);
        repeat (hold) begin
            @(posedge clk);
            #10;
        end
        inst_req = 1'b0;
        wait_ack(1'b0);
    endtask

    // compare against the model at the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (inst_ack && !ack_q) begin
                if (expected_q.size() == 0) begin
                    report_failure("inst_ack rose with no instruction outstanding");
                end else begin
                    exp_rec = expected_q.pop_front();
                    if (exp_rec.wen) begin
                        check_value(exp_rec.value, retire.value);
                    end
                    check_retire(exp_rec, retire);
                    last_retire = retire;
                end
            end else begin
                // record holds between retirements and while req is held
                check_retire(last_retire, retire);
            end
            ack_q = inst_ack;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            report_failure($sformatf("Timeout: DUT stopped acknowledging after %0d cycles",
                                     cycles));
        end
    end

    initial begin
        rst_n       = 1'b0;
        inst_req    = 1'b0;
        inst        = '0;
        ref_pc      = `RV_RESET_PC;
        last_retire = '0;
        foreach (ref_regs[k]) begin
            ref_regs[k] = '0;
        end
        void'($urandom(32'h30c3_2701));

        // first retirement starts at the reset pc
        prog.push_back(encode_i(12'd5, 5'd0, 3'b000, 5'd1, 7'b0010011));
        // wide random values in every register
        for (k = 1; k < `RV_NREGS; k++) begin
            prog.push_back({20'($urandom()), reg_idx_t'(k), 7'b0110111});
            prog.push_back(encode_i(12'($urandom()), reg_idx_t'(k), 3'b000, reg_idx_t'(k),
                                    7'b0010011));
        end
        // x0 as destination and then as source
        prog.push_back(encode_i(12'h7ff, 5'd5, 3'b000, 5'd0, 7'b0010011));
        prog.push_back(encode_r(7'b0, 5'd7, 5'd0, 3'b000, 5'd6, 7'b0110011));
        prog.push_back(encode_r(7'b0100000, 5'd0, 5'd8, 3'b000, 5'd9, 7'b0110011));
        for (k = 0; k < 150; k++) begin
            prog.push_back(random_alu());
        end
        // equal and both orders give each branch both outcomes
        foreach (br_f3[k]) begin
            prog.push_back(encode_b(13'($urandom()) & 13'h1ffe, 5'd3, 5'd3, br_f3[k]));
            prog.push_back(encode_b(13'($urandom()) & 13'h1ffe, 5'd4, 5'd3, br_f3[k]));
            prog.push_back(encode_b(13'($urandom()) & 13'h1ffe, 5'd3, 5'd4, br_f3[k]));
        end
        prog.push_back(encode_j(21'($urandom()) & 21'h1ffffe, 5'd1));
        // odd offset exercises the cleared target bit
        prog.push_back(encode_i(12'($urandom()) | 12'h001, 5'd2, 3'b000, 5'd10, 7'b1100111));
        prog.push_back(encode_i(12'($urandom()) | 12'h001, 5'd11, 3'b000, 5'd0, 7'b1100111));
        prog.push_back({20'h0, 5'd12, 7'b0010111});
        foreach (bad_opc[k]) begin
            prog.push_back({25'($urandom()), bad_opc[k]});
        end
        for (k = 0; k < 20; k++) begin
            prog.push_back(random_alu());
        end
        cycle_limit = prog.size() * 12 + 50;

        repeat (5) @(posedge clk);
        #10;
        rst_n = 1'b1;
        if (inst_ack !== 1'b0) begin
            report_failure("inst_ack is not low after reset");
        end
        foreach (prog[k]) begin
            run_instruction(prog[k]);
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== sim/rv_exec_assertions.sv ====
`timescale 1ns/1ps

module rv_exec_assertions (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 inst_req,
    input logic                 inst_ack,
    input rv_exec_pkg::retire_t retire
);
    import rv_exec_pkg::*;

    // ack only answers a pending request
    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(inst_ack) |-> $past(inst_req))
        else $error("inst_ack rose without inst_req high");

    // x0 is never reported as written
    no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
        retire.wen |-> (retire.rd != '0))
        else $error("retire reports a write to x0");

    // ack held until req drops
    ack_holds: assert property (@(posedge clk) disable iff (!rst_n)
        (inst_ack && inst_req) |=> inst_ack)
        else $error("inst_ack fell while inst_req was still high");

endmodule

bind rv_exec_top rv_exec_assertions assertions_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .inst_req (inst_req),
    .inst_ack (inst_ack),
    .retire   (retire)
);

// ==== logic/rv_exec_top.sv ====
`timescale 1ns/1ps

module rv_exec_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 inst_req,
    input  rv_exec_pkg::inst_t   inst,
    output logic                 inst_ack,
    output rv_exec_pkg::retire_t retire
);
    import rv_exec_pkg::*;

    // register file ports
    reg_idx_t rs1_addr;
    reg_idx_t rs2_addr;
    xlen_t    rs1_data;
    xlen_t    rs2_data;
    logic     wr_en;
    reg_idx_t wr_addr;
    xlen_t    wr_data;

    // stage handoff
    logic     dec_valid;
    decoded_t dec;
    logic     ex_valid;
    exec_t    ex;
    xlen_t    pc;

    rv_regfile regfile_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

    rv_decode decode_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .inst_req  (inst_req),
        .inst      (inst),
        .pc        (pc),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .dec_valid (dec_valid),
        .dec       (dec)
    );

    rv_execute execute_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .dec_valid (dec_valid),
        .dec       (dec),
        .ex_valid  (ex_valid),
        .ex        (ex)
    );

    // pc loops back from result to decode
    rv_result result_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .ex_valid (ex_valid),
        .ex       (ex),
        .inst_req (inst_req),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .pc       (pc),
        .inst_ack (inst_ack),
        .retire   (retire)
    );

endmodule

// ==== logic/rv_result.sv ====
`timescale 1ns/1ps
`include "rv_exec_cfg.svh"

module rv_result (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  ex_valid,
    input  rv_exec_pkg::exec_t    ex,
    input  logic                  inst_req,
    output logic                  wr_en,
    output rv_exec_pkg::reg_idx_t wr_addr,
    output rv_exec_pkg::xlen_t    wr_data,
    output rv_exec_pkg::xlen_t    pc,
    output logic                  inst_ack,
    output rv_exec_pkg::retire_t  retire
);

    // write strobe lasts exactly the ex_valid cycle
    // regfile commits at the same edge that raises ack
    assign wr_en   = ex_valid & ex.wen;
    assign wr_addr = ex.rd;
    assign wr_data = ex.value;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc       <= `RV_RESET_PC;
            inst_ack <= 1'b0;
            retire   <= '0;
        end else begin
            if (ex_valid) begin
                pc             <= ex.next_pc;
                retire.pc      <= ex.pc;
                retire.next_pc <= ex.next_pc;
                retire.rd      <= ex.rd;
                retire.value   <= ex.value;
                retire.wen     <= ex.wen;
                // instruction done, close the first half of the handshake
                inst_ack       <= 1'b1;
            end else if (!inst_req) begin
                // req dropped, release ack
                inst_ack <= 1'b0;
            end
        end
    end

endmodule

// ==== logic/rv_execute.sv ====
`timescale 1ns/1ps
`include "rv_exec_cfg.svh"

module rv_execute (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  dec_valid,
    input  rv_exec_pkg::decoded_t dec,
    output logic                  ex_valid,
    output rv_exec_pkg::exec_t    ex
);
    import rv_exec_pkg::*;

    logic [5:0] shamt;
    xlen_t      alu_res;
    xlen_t      alu_word;
    xlen_t      seq_pc;
    xlen_t      jump_base;
    xlen_t      target;
    logic       taken;
    logic       is_jump;
    exec_t      ex_next;

    // rv64 shifts use the low 6 bits
    assign shamt = dec.op_b[5:0];

    always_comb begin
        case (dec.alu_op)
            ALU_ADD:    alu_res = dec.op_a + dec.op_b;
            ALU_SUB:    alu_res = dec.op_a - dec.op_b;
            ALU_SLL:    alu_res = dec.op_a << shamt;
            ALU_SLT:    alu_res = xlen_t'($signed(dec.op_a) < $signed(dec.op_b));
            ALU_SLTU:   alu_res = xlen_t'(dec.op_a < dec.op_b);
            ALU_XOR:    alu_res = dec.op_a ^ dec.op_b;
            ALU_SRL:    alu_res = dec.op_a >> shamt;
            ALU_SRA:    alu_res = xlen_t'($signed(dec.op_a) >>> shamt);
            ALU_OR:     alu_res = dec.op_a | dec.op_b;
            ALU_AND:    alu_res = dec.op_a & dec.op_b;
            ALU_PASS_B: alu_res = dec.op_b;
            default:    alu_res = '0;
        endcase
    end

    // w forms keep the low word, sign extended from bit 31
    assign alu_word = dec.word ? {{(`RV_XLEN-32){alu_res[31]}}, alu_res[31:0]} : alu_res;

    // branch compare works on rs1 and rs2
    always_comb begin
        case (dec.br_kind)
            BR_JAL,
            BR_JALR: taken = 1'b1;
            BR_BEQ:  taken = (dec.op_a == dec.op_b);
            BR_BNE:  taken = (dec.op_a != dec.op_b);
            BR_BLT:  taken = ($signed(dec.op_a) < $signed(dec.op_b));
            BR_BGE:  taken = ($signed(dec.op_a) >= $signed(dec.op_b));
            BR_BLTU: taken = (dec.op_a < dec.op_b);
            BR_BGEU: taken = (dec.op_a >= dec.op_b);
            default: taken = 1'b0;
        endcase
    end

    assign is_jump   = (dec.br_kind == BR_JAL) || (dec.br_kind == BR_JALR);
    assign seq_pc    = dec.pc + xlen_t'(4);
    // jalr is relative to rs1, everything else to pc
    assign jump_base = (dec.br_kind == BR_JALR) ? dec.op_a : dec.pc;
    assign target    = jump_base + dec.imm;

    always_comb begin
        ex_next.pc      = dec.pc;
        // link value replaces the alu result on jumps
        ex_next.value   = is_jump ? seq_pc : alu_word;
        ex_next.rd      = dec.rd;
        ex_next.wen     = dec.wen;
        ex_next.next_pc = seq_pc;
        if (taken) begin
            ex_next.next_pc = (dec.br_kind == BR_JALR) ? {target[`RV_XLEN-1:1], 1'b0} : target;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            ex <= ex_next;
        end
    end

endmodule

// ==== logic/rv_decode.sv ====
`timescale 1ns/1ps
`include "rv_exec_cfg.svh"

module rv_decode (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  inst_req,
    input  rv_exec_pkg::inst_t    inst,
    input  rv_exec_pkg::xlen_t    pc,
    output rv_exec_pkg::reg_idx_t rs1_addr,
    output rv_exec_pkg::reg_idx_t rs2_addr,
    input  rv_exec_pkg::xlen_t    rs1_data,
    input  rv_exec_pkg::xlen_t    rs2_data,
    output logic                  dec_valid,
    output rv_exec_pkg::decoded_t dec
);
    import rv_exec_pkg::*;

    localparam logic [6:0] OPC_LUI      = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
    localparam logic [6:0] OPC_JAL      = 7'b1101111;
    localparam logic [6:0] OPC_JALR     = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
    localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_OP       = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM32 = 7'b0011011;
    localparam logic [6:0] OPC_OP32     = 7'b0111011;

    logic     req_q;
    logic     req_rise;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    xlen_t    imm_i;
    xlen_t    imm_u;
    xlen_t    imm_j;
    xlen_t    imm_b;
    opa_sel_e a_sel;
    opb_sel_e b_sel;
    xlen_t    imm;
    alu_op_e  alu_op;
    br_kind_e br_kind;
    logic     word_op;
    logic     writes_rd;
    logic     legal;
    decoded_t dec_next;

    // shared funct3 map of OP and OP-IMM, alt picks sub / sra
    function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    // a new request is a rising req
    assign req_rise = inst_req & ~req_q;

    assign opcode   = inst[6:0];
    assign funct3   = inst[14:12];
    assign funct7   = inst[31:25];
    assign rs1_addr = inst[19:15];
    assign rs2_addr = inst[24:20];

    // sign extended immediates
    assign imm_i = {{(`RV_XLEN-12){inst[31]}}, inst[31:20]};
    assign imm_u = {{(`RV_XLEN-32){inst[31]}}, inst[31:12], 12'b0};
    assign imm_j = {{(`RV_XLEN-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_b = {{(`RV_XLEN-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};

    always_comb begin
        a_sel     = OPA_ZERO;
        b_sel     = OPB_ZERO;
        imm       = '0;
        alu_op    = ALU_ADD;
        br_kind   = BR_NONE;
        word_op   = 1'b0;
        writes_rd = 1'b0;
        legal     = 1'b1;
        case (opcode)
            OPC_LUI: begin
                b_sel     = OPB_IMM;
                imm       = imm_u;
                alu_op    = ALU_PASS_B;
                writes_rd = 1'b1;
            end
            OPC_AUIPC: begin
                a_sel     = OPA_PC;
                b_sel     = OPB_IMM;
                imm       = imm_u;
                writes_rd = 1'b1;
            end
            OPC_JAL: begin
                imm       = imm_j;
                br_kind   = BR_JAL;
                writes_rd = 1'b1;
            end
            OPC_JALR: begin
                // target base comes through operand a
                a_sel     = OPA_RS1;
                imm       = imm_i;
                br_kind   = BR_JALR;
                writes_rd = 1'b1;
                legal     = (funct3 == 3'b000);
            end
            OPC_BRANCH: begin
                a_sel = OPA_RS1;
                b_sel = OPB_RS2;
                imm   = imm_b;
                case (funct3)
                    3'b000:  br_kind = BR_BEQ;
                    3'b001:  br_kind = BR_BNE;
                    3'b100:  br_kind = BR_BLT;
                    3'b101:  br_kind = BR_BGE;
                    3'b110:  br_kind = BR_BLTU;
                    3'b111:  br_kind = BR_BGEU;
                    default: legal = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                a_sel     = OPA_RS1;
                b_sel     = OPB_IMM;
                imm       = imm_i;
                writes_rd = 1'b1;
                alu_op    = alu_from_f3(funct3, (funct3 == 3'b101) && inst[30]);
                // shift immediates carry a 6 bit shamt
                if (funct3 == 3'b001) begin
                    legal = (inst[31:26] == 6'b0);
                end else if (funct3 == 3'b101) begin
                    legal = !inst[31] && (inst[29:26] == 4'b0);
                end
            end
            OPC_OP: begin
                a_sel     = OPA_RS1;
                b_sel     = OPB_RS2;
                writes_rd = 1'b1;
                alu_op    = alu_from_f3(funct3, funct7[5]);
                legal     = (funct7 == 7'b0) ||
                            (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            OPC_OP_IMM32: begin
                // addiw only
                a_sel     = OPA_RS1;
                b_sel     = OPB_IMM;
                imm       = imm_i;
                word_op   = 1'b1;
                writes_rd = 1'b1;
                legal     = (funct3 == 3'b000);
            end
            OPC_OP32: begin
                // addw and subw only
                a_sel     = OPA_RS1;
                b_sel     = OPB_RS2;
                word_op   = 1'b1;
                writes_rd = 1'b1;
                alu_op    = funct7[5] ? ALU_SUB : ALU_ADD;
                legal     = (funct3 == 3'b000) && (funct7 == 7'b0 || funct7 == 7'b0100000);
            end
            default: legal = 1'b0;
        endcase
        // unknown encodings fall back to a no-op with value zero
        if (!legal) begin
            a_sel     = OPA_ZERO;
            b_sel     = OPB_ZERO;
            alu_op    = ALU_ADD;
            br_kind   = BR_NONE;
            word_op   = 1'b0;
            writes_rd = 1'b0;
        end
    end

    // operand muxes and the x0 write filter
    always_comb begin
        dec_next.pc = pc;
        case (a_sel)
            OPA_RS1: dec_next.op_a = rs1_data;
            OPA_PC:  dec_next.op_a = pc;
            default: dec_next.op_a = '0;
        endcase
        case (b_sel)
            OPB_RS2: dec_next.op_b = rs2_data;
            OPB_IMM: dec_next.op_b = imm;
            default: dec_next.op_b = '0;
        endcase
        dec_next.imm     = imm;
        dec_next.rd      = inst[11:7];
        dec_next.wen     = writes_rd && (inst[11:7] != '0);
        dec_next.word    = word_op;
        dec_next.alu_op  = alu_op;
        dec_next.br_kind = br_kind;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_q     <= 1'b0;
            dec_valid <= 1'b0;
        end else begin
            req_q     <= inst_req;
            dec_valid <= req_rise;
        end
    end

    // payload only loads on a new request
    always_ff @(posedge clk) begin
        if (req_rise) begin
            dec <= dec_next;
        end
    end

endmodule

// ==== logic/rv_regfile.sv ====
`timescale 1ns/1ps
`include "rv_exec_cfg.svh"

module rv_regfile (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rv_exec_pkg::reg_idx_t rs1_addr,
    input  rv_exec_pkg::reg_idx_t rs2_addr,
    output rv_exec_pkg::xlen_t   rs1_data,
    output rv_exec_pkg::xlen_t   rs2_data,
    input  logic                 wr_en,
    input  rv_exec_pkg::reg_idx_t wr_addr,
    input  rv_exec_pkg::xlen_t   wr_data
);
    import rv_exec_pkg::*;

    // x0 stays zero since decode never asks for a write to it
    xlen_t regs [`RV_NREGS];

    // combinational read ports
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

    // single write port, whole array cleared on reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regs <= '{default: '0};
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

// ==== logic/rv_exec_pkg.sv ====
`include "rv_exec_cfg.svh"

package rv_exec_pkg;

    typedef logic [`RV_XLEN-1:0]           xlen_t;
    typedef logic [$clog2(`RV_NREGS)-1:0]  reg_idx_t;
    typedef logic [`RV_INST_W-1:0]         inst_t;

    // alu operations, PASS_B forwards operand b (lui)
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    // control flow kind, nine values
    typedef enum logic [3:0] {
        BR_NONE, BR_JAL, BR_JALR, BR_BEQ, BR_BNE,
        BR_BLT, BR_BGE, BR_BLTU, BR_BGEU
    } br_kind_e;

    // operand a source
    typedef enum logic [1:0] {OPA_ZERO, OPA_RS1, OPA_PC} opa_sel_e;

    // operand b source
    typedef enum logic [1:0] {OPB_ZERO, OPB_RS2, OPB_IMM} opb_sel_e;

    // decode to execute
    typedef struct packed {
        xlen_t    pc;
        xlen_t    op_a;
        xlen_t    op_b;
        xlen_t    imm;
        reg_idx_t rd;
        logic     wen;
        logic     word;
        alu_op_e  alu_op;
        br_kind_e br_kind;
    } decoded_t;

    // execute to result
    typedef struct packed {
        xlen_t    pc;
        xlen_t    value;
        reg_idx_t rd;
        logic     wen;
        xlen_t    next_pc;
    } exec_t;

    // retire record seen at the top level
    typedef struct packed {
        xlen_t    pc;
        xlen_t    next_pc;
        reg_idx_t rd;
        xlen_t    value;
        logic     wen;
    } retire_t;

endpackage

// ==== logic/rv_exec_cfg.svh ====
`ifndef RV_EXEC_CFG_SVH
`define RV_EXEC_CFG_SVH

// integer register and data path width
`define RV_XLEN 64

// architectural register count, x0 included
`define RV_NREGS 32

// raw instruction word
`define RV_INST_W 32

// first fetch address after reset
`define RV_RESET_PC 64'h8000_0000

`endif
